// ==== alu_cluster_cfg.svh ====
`ifndef ALU_CLUSTER_CFG_SVH
`define ALU_CLUSTER_CFG_SVH

// number of execute lanes in the cluster
`define NUM_LANES 4

// bit positions the shifter moves per cycle
`define SHIFT_STEP 8

// issue-order tag width
// the tag has to count at least twice NUM_LANES so that an old
// tag still held in a finished lane is never mistaken for the
// tag retire is waiting on
`define TAG_W 3

`endif

// ==== alu_types_pkg.sv ====
`default_nettype none

`include "alu_cluster_cfg.svh"

package alu_types_pkg;

    // data word
    typedef logic [31:0] word_t;

    // NZCV, N in the top bit
    typedef logic [3:0] flags_t;

    localparam int FLAG_N = 3;
    localparam int FLAG_Z = 2;
    localparam int FLAG_C = 1;
    localparam int FLAG_V = 0;

    // issue-order tag, wraps
    typedef logic [`TAG_W-1:0] tag_t;

    // lane index, at least one bit
    typedef logic [(`NUM_LANES > 1 ? $clog2(`NUM_LANES) : 1)-1:0] lane_idx_t;

    // shift amount 0..31
    typedef logic [4:0] shamt_t;

endpackage

`default_nettype wire

// ==== isa_pkg.sv ====
`default_nettype none

package isa_pkg;

    // data-processing opcode
    typedef enum logic [3:0] {
        ALU_OP_MOV            = 4'h0,
        ALU_OP_NOT            = 4'h1,
        ALU_OP_AND            = 4'h2,
        ALU_OP_TEST           = 4'h3,
        ALU_OP_XOR            = 4'h4,
        ALU_OP_TEST_EXCLUSIVE = 4'h5,
        ALU_OP_OR             = 4'h6,
        ALU_OP_BIT_CLEAR      = 4'h7,
        ALU_OP_ADD            = 4'h8,
        ALU_OP_CMP_NEG        = 4'h9,
        ALU_OP_ADC            = 4'ha,
        ALU_OP_SUB            = 4'hb,
        ALU_OP_CMP            = 4'hc,
        ALU_OP_SBC            = 4'hd,
        ALU_OP_SUB_REVERSED   = 4'he,
        ALU_OP_SBC_REVERSED   = 4'hf
    } alu_op_t;

    // shift type on operand b
    typedef enum logic [1:0] {
        SHIFT_LSL = 2'b00,
        SHIFT_LSR = 2'b01,
        SHIFT_ASR = 2'b10,
        SHIFT_ROR = 2'b11
    } shift_t;

endpackage

`default_nettype wire

// ==== lane_if.sv ====
`timescale 1ns/10ps
`default_nettype none

// dispatch -> lane -> retire
interface lane_if import alu_types_pkg::*, isa_pkg::*; ();
    logic    start;
    alu_op_t op;
    word_t   op_a;
    word_t   op_b;
    shift_t  shift;
    shamt_t  shamt;
    flags_t  flags_in;
    logic    set_flags;
    tag_t    tag;
    logic    busy;
    logic    done;
    word_t   result;
    flags_t  flags_out;
    logic    write_result;
    tag_t    tag_out;
    // frees the lane, one cycle pulse
    logic    release_lane;

    modport dispatch_side (output start, op, op_a, op_b, shift, shamt, flags_in, set_flags,
        tag, input busy);
    modport lane_side (input start, op, op_a, op_b, shift, shamt, flags_in, tag, release_lane,
        output busy, done, result, flags_out, write_result, tag_out);
    modport retire_side (input done, result, flags_out, write_result, tag_out, set_flags,
        output release_lane);
endinterface

// shifted operand into the ALU
interface shifter_if import alu_types_pkg::*; ();
    word_t op_b;
    logic  carry_out;

    modport shifter_side (output op_b, carry_out);
    modport alu_side (input op_b, carry_out);
endinterface

`default_nettype wire

// ==== shift_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "alu_cluster_cfg.svh"

module shift_unit import alu_types_pkg::*, isa_pkg::*; (
    input  logic   clk,
    input  logic   reset,
    input  logic   start,
    input  shift_t shift,
    input  shamt_t shamt,
    input  word_t  value,
    input  logic   carry_in,
    output logic   done,
    shifter_if.shifter_side out
);

    typedef enum logic [1:0] {
        IDLE,
        SHIFTING,
        FINISHED
    } state_t;

    state_t      state;
    shift_t      shift_q;
    shamt_t      remaining;
    shamt_t      step_amt;
    word_t       work;
    logic        carry;
    word_t       work_next;
    logic        carry_next;
    logic [32:0] ext;

    assign step_amt = (remaining > shamt_t'(`SHIFT_STEP)) ? shamt_t'(`SHIFT_STEP) : remaining;

    // one partial shift; the extra bit catches the last bit shifted out
    always_comb begin
        ext        = 33'h0;
        work_next  = work;
        carry_next = carry;
        case (shift_q)
            SHIFT_LSL: begin
                ext        = {1'b0, work} << step_amt;
                work_next  = ext[31:0];
                carry_next = ext[32];
            end
            SHIFT_LSR: begin
                ext        = {work, 1'b0} >> step_amt;
                work_next  = ext[32:1];
                carry_next = ext[0];
            end
            SHIFT_ASR: begin
                ext        = $signed({work, 1'b0}) >>> step_amt;
                work_next  = ext[32:1];
                carry_next = ext[0];
            end
            SHIFT_ROR: begin
                work_next  = (work >> step_amt) | (work << (6'd32 - step_amt));
                carry_next = work_next[31];
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:     if (start) state <= (shamt == '0) ? FINISHED : SHIFTING;
                SHIFTING: if (remaining <= shamt_t'(`SHIFT_STEP)) state <= FINISHED;
                default:  state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start && state == IDLE) begin
            work      <= value;
            carry     <= carry_in;
            remaining <= shamt;
            shift_q   <= shift;
        end else if (state == SHIFTING) begin
            work      <= work_next;
            carry     <= carry_next;
            remaining <= remaining - step_amt;
        end
    end

    assign done          = (state == FINISHED);
    assign out.op_b      = work;
    assign out.carry_out = carry;

endmodule

`default_nettype wire

// ==== alu.sv ====
`timescale 1ns/10ps
`default_nettype none

module alu import alu_types_pkg::*, isa_pkg::*; (
    input  alu_op_t op,
    input  word_t   op_a,
    input  flags_t  flags_in,
    shifter_if.alu_side shifter_bus,
    output word_t   result,
    output flags_t  flags_out,
    output logic    write_result
);

    word_t       op_b;
    logic        carry_in;
    logic [32:0] sum;
    logic        c;
    logic        v;

    assign op_b     = shifter_bus.op_b;
    assign carry_in = flags_in[FLAG_C];

    always_comb begin
        // logical ops keep the shifter carry and the incoming V
        result = 32'h0;
        sum    = 33'h0;
        c      = shifter_bus.carry_out;
        v      = flags_in[FLAG_V];

        case (op)
            ALU_OP_MOV: begin
                result = op_b;
            end
            ALU_OP_NOT: begin
                result = ~op_b;
            end
            ALU_OP_AND, ALU_OP_TEST: begin
                result = op_a & op_b;
            end
            ALU_OP_XOR, ALU_OP_TEST_EXCLUSIVE: begin
                result = op_a ^ op_b;
            end
            ALU_OP_OR: begin
                result = op_a | op_b;
            end
            ALU_OP_BIT_CLEAR: begin
                result = op_a & ~op_b;
            end
            ALU_OP_ADD, ALU_OP_CMP_NEG: begin
                sum    = {1'b0, op_a} + {1'b0, op_b};
                result = sum[31:0];
                c      = sum[32];
                v      = ~(op_a[31] ^ op_b[31]) & (op_a[31] ^ result[31]);
            end
            ALU_OP_ADC: begin
                sum    = {1'b0, op_a} + {1'b0, op_b} + {32'h0, carry_in};
                result = sum[31:0];
                c      = sum[32];
                v      = ~(op_a[31] ^ op_b[31]) & (op_a[31] ^ result[31]);
            end
            ALU_OP_SUB, ALU_OP_CMP: begin
                sum    = {1'b0, op_a} - {1'b0, op_b};
                result = sum[31:0];
                // carry is NOT borrow
                c      = ~sum[32];
                v      = (op_a[31] ^ op_b[31]) & (op_a[31] ^ result[31]);
            end
            ALU_OP_SBC: begin
                sum    = {1'b0, op_a} - {1'b0, op_b} - {32'h0, ~carry_in};
                result = sum[31:0];
                c      = ~sum[32];
                v      = (op_a[31] ^ op_b[31]) & (op_a[31] ^ result[31]);
            end
            ALU_OP_SUB_REVERSED: begin
                sum    = {1'b0, op_b} - {1'b0, op_a};
                result = sum[31:0];
                c      = ~sum[32];
                v      = (op_a[31] ^ op_b[31]) & (op_b[31] ^ result[31]);
            end
            ALU_OP_SBC_REVERSED: begin
                sum    = {1'b0, op_b} - {1'b0, op_a} - {32'h0, ~carry_in};
                result = sum[31:0];
                c      = ~sum[32];
                v      = (op_a[31] ^ op_b[31]) & (op_b[31] ^ result[31]);
            end
        endcase

        flags_out[FLAG_N] = result[31];
        flags_out[FLAG_Z] = (result == 32'h0);
        flags_out[FLAG_C] = c;
        flags_out[FLAG_V] = v;
    end

    // tests and compares only update flags
    assign write_result = !(op inside {ALU_OP_TEST, ALU_OP_TEST_EXCLUSIVE,
                                       ALU_OP_CMP, ALU_OP_CMP_NEG});

endmodule

`default_nettype wire

// ==== exec_lane.sv ====
`timescale 1ns/10ps
`default_nettype none

module exec_lane import alu_types_pkg::*, isa_pkg::*; (
    input logic clk,
    input logic reset,
    lane_if.lane_side bus
);

    shifter_if shifter_bus ();

    alu_op_t op_q;
    word_t   op_a_q;
    flags_t  flags_q;
    logic    shift_done;
    word_t   alu_result;
    flags_t  alu_flags;
    logic    alu_write;

    shift_unit shift_unit_i (
        .clk      (clk),
        .reset    (reset),
        .start    (bus.start),
        .shift    (bus.shift),
        .shamt    (bus.shamt),
        .value    (bus.op_b),
        .carry_in (bus.flags_in[FLAG_C]),
        .done     (shift_done),
        .out      (shifter_bus)
    );

    alu alu_i (
        .op           (op_q),
        .op_a         (op_a_q),
        .flags_in     (flags_q),
        .shifter_bus  (shifter_bus),
        .result       (alu_result),
        .flags_out    (alu_flags),
        .write_result (alu_write)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            bus.busy <= 1'b0;
            bus.done <= 1'b0;
        end else begin
            if (bus.start) begin
                bus.busy <= 1'b1;
            end else if (bus.release_lane) begin
                bus.busy <= 1'b0;
            end
            // held until retire takes it
            if (shift_done) begin
                bus.done <= 1'b1;
            end else if (bus.release_lane) begin
                bus.done <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (bus.start) begin
            op_q        <= bus.op;
            op_a_q      <= bus.op_a;
            flags_q     <= bus.flags_in;
            bus.tag_out <= bus.tag;
        end
        if (shift_done) begin
            bus.result       <= alu_result;
            bus.flags_out    <= alu_flags;
            bus.write_result <= alu_write;
        end
    end

endmodule

`default_nettype wire

// ==== dispatch.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "alu_cluster_cfg.svh"

module dispatch import alu_types_pkg::*, isa_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  logic    in_valid,
    input  alu_op_t in_op,
    input  word_t   in_a,
    input  word_t   in_b,
    input  shift_t  in_shift,
    input  shamt_t  in_shamt,
    input  flags_t  in_flags,
    input  logic    in_set_flags,
    input  logic    retired,
    output logic    busy,
    lane_if.dispatch_side lanes [`NUM_LANES]
);

    localparam int COUNT_W = $clog2(`NUM_LANES + 1);

    logic [`NUM_LANES-1:0] free;
    logic                  any_free;
    lane_idx_t             sel;
    logic                  accept;
    tag_t                  next_tag;
    logic [COUNT_W-1:0]    in_flight;

    for (genvar i = 0; i < `NUM_LANES; i++) begin : g_lane
        // lane busy only rises after start, so the pulse cycle counts as taken
        assign free[i] = !lanes[i].busy && !lanes[i].start;

        always_ff @(posedge clk) begin
            if (reset) begin
                lanes[i].start <= 1'b0;
            end else begin
                lanes[i].start <= accept && (sel == lane_idx_t'(i));
            end
        end

        // fields hold until the next issue to this lane, retire reads set_flags
        always_ff @(posedge clk) begin
            if (accept && (sel == lane_idx_t'(i))) begin
                lanes[i].op        <= in_op;
                lanes[i].op_a      <= in_a;
                lanes[i].op_b      <= in_b;
                lanes[i].shift     <= in_shift;
                lanes[i].shamt     <= in_shamt;
                lanes[i].flags_in  <= in_flags;
                lanes[i].set_flags <= in_set_flags;
                lanes[i].tag       <= next_tag;
            end
        end
    end

    // lowest free lane wins
    always_comb begin
        any_free = 1'b0;
        sel      = '0;
        for (int i = `NUM_LANES - 1; i >= 0; i--) begin
            if (free[i]) begin
                any_free = 1'b1;
                sel      = lane_idx_t'(i);
            end
        end
    end

    assign busy   = !any_free || (in_flight == COUNT_W'(`NUM_LANES));
    assign accept = in_valid && !busy;

    always_ff @(posedge clk) begin
        if (reset) begin
            in_flight <= '0;
            next_tag  <= '0;
        end else begin
            in_flight <= in_flight + COUNT_W'(accept) - COUNT_W'(retired);
            if (accept) begin
                next_tag <= next_tag + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== retire.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "alu_cluster_cfg.svh"

module retire import alu_types_pkg::*; (
    input  logic   clk,
    input  logic   reset,
    lane_if.retire_side lanes [`NUM_LANES],
    output logic   retired,
    output logic   out_valid,
    output word_t  out_result,
    output logic   out_write,
    output flags_t out_flags,
    output tag_t   out_tag
);

    logic [`NUM_LANES-1:0] lane_done;
    logic [`NUM_LANES-1:0] lane_write;
    logic [`NUM_LANES-1:0] lane_set_flags;
    tag_t                  lane_tag [`NUM_LANES];
    word_t                 lane_result [`NUM_LANES];
    flags_t                lane_flags [`NUM_LANES];
    tag_t                  expected_tag;
    logic                  hit;
    lane_idx_t             pick;
    flags_t                flags_q;

    for (genvar i = 0; i < `NUM_LANES; i++) begin : g_lane
        assign lane_done[i]      = lanes[i].done;
        assign lane_write[i]     = lanes[i].write_result;
        assign lane_set_flags[i] = lanes[i].set_flags;
        assign lane_tag[i]       = lanes[i].tag_out;
        assign lane_result[i]    = lanes[i].result;
        assign lane_flags[i]     = lanes[i].flags_out;

        always_ff @(posedge clk) begin
            if (reset) begin
                lanes[i].release_lane <= 1'b0;
            end else begin
                lanes[i].release_lane <= hit && (pick == lane_idx_t'(i));
            end
        end
    end

    // at most one finished lane holds the expected tag
    always_comb begin
        hit  = 1'b0;
        pick = '0;
        for (int i = 0; i < `NUM_LANES; i++) begin
            if (lane_done[i] && (lane_tag[i] == expected_tag)) begin
                hit  = 1'b1;
                pick = lane_idx_t'(i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid    <= 1'b0;
            expected_tag <= '0;
            flags_q      <= '0;
        end else begin
            out_valid <= hit;
            if (hit) begin
                expected_tag <= expected_tag + 1'b1;
                // no result write means a compare or test
                if (lane_set_flags[pick] || !lane_write[pick]) begin
                    flags_q <= lane_flags[pick];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (hit) begin
            out_result <= lane_result[pick];
            out_write  <= lane_write[pick];
            out_tag    <= lane_tag[pick];
        end
    end

    assign retired   = out_valid;
    assign out_flags = flags_q;

endmodule

`default_nettype wire

// ==== alu_cluster.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "alu_cluster_cfg.svh"

module alu_cluster import alu_types_pkg::*, isa_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  logic    in_valid,
    input  alu_op_t in_op,
    input  word_t   in_a,
    input  word_t   in_b,
    input  shift_t  in_shift,
    input  shamt_t  in_shamt,
    input  flags_t  in_flags,
    input  logic    in_set_flags,
    output logic    busy,
    output logic    out_valid,
    output word_t   out_result,
    output logic    out_write,
    output flags_t  out_flags,
    output tag_t    out_tag
);

    lane_if lanes [`NUM_LANES] ();

    logic retired;

    dispatch dispatch_i (
        .clk          (clk),
        .reset        (reset),
        .in_valid     (in_valid),
        .in_op        (in_op),
        .in_a         (in_a),
        .in_b         (in_b),
        .in_shift     (in_shift),
        .in_shamt     (in_shamt),
        .in_flags     (in_flags),
        .in_set_flags (in_set_flags),
        .retired      (retired),
        .busy         (busy),
        .lanes        (lanes)
    );

    for (genvar i = 0; i < `NUM_LANES; i++) begin : g_lane
        exec_lane exec_lane_i (
            .clk   (clk),
            .reset (reset),
            .bus   (lanes[i])
        );
    end

    retire retire_i (
        .clk        (clk),
        .reset      (reset),
        .lanes      (lanes),
        .retired    (retired),
        .out_valid  (out_valid),
        .out_result (out_result),
        .out_write  (out_write),
        .out_flags  (out_flags),
        .out_tag    (out_tag)
    );

endmodule

`default_nettype wire

// ==== alu_cluster_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "alu_cluster_cfg.svh"

module alu_cluster_tb import alu_types_pkg::*, isa_pkg::*; ();

    logic    clk;
    logic    reset;
    logic    in_valid;
    alu_op_t in_op;
    word_t   in_a;
    word_t   in_b;
    shift_t  in_shift;
    shamt_t  in_shamt;
    flags_t  in_flags;
    logic    in_set_flags;
    logic    busy;
    logic    out_valid;
    word_t   out_result;
    logic    out_write;
    flags_t  out_flags;
    tag_t    out_tag;

    // expected retirements in issue order
    word_t  exp_result [$];
    logic   exp_write [$];
    flags_t exp_flags [$];
    tag_t   exp_tag [$];

    flags_t      sticky;
    logic [31:0] rng_state;
    int          issued_count;
    int          retired_count;
    int          value_errors;
    int          other_errors;
    int          wait_cycles;
    int          k;
    int          j;
    word_t       rv;
    word_t       e_r;
    logic        e_w;
    flags_t      e_f;
    tag_t        e_t;

    alu_cluster alu_cluster_i (
        .clk          (clk),
        .reset        (reset),
        .in_valid     (in_valid),
        .in_op        (in_op),
        .in_a         (in_a),
        .in_b         (in_b),
        .in_shift     (in_shift),
        .in_shamt     (in_shamt),
        .in_flags     (in_flags),
        .in_set_flags (in_set_flags),
        .busy         (busy),
        .out_valid    (out_valid),
        .out_result   (out_result),
        .out_write    (out_write),
        .out_flags    (out_flags),
        .out_tag      (out_tag)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic word_t next_random();
        rng_state = xorshift(rng_state);
        return rng_state;
    endfunction

    // ARM barrel shifter rules giving {carry, shifted value}
    function automatic logic [32:0] shift_ref(input shift_t sh, input shamt_t amt,
                                              input word_t b, input logic cin);
        logic [63:0] wide;
        word_t       rot;
        if (amt == 5'd0) begin
            return {cin, b};
        end
        case (sh)
            SHIFT_LSL: begin
                wide = {32'h0, b} << amt;
                return {wide[32], wide[31:0]};
            end
            SHIFT_LSR: begin
                wide = {b, 32'h0} >> amt;
                return {wide[31], wide[63:32]};
            end
            SHIFT_ASR: begin
                wide = $signed({b, 32'h0}) >>> amt;
                return {wide[31], wide[63:32]};
            end
            default: begin
                wide = {b, b} >> amt;
                rot  = wide[31:0];
                return {rot[31], rot};
            end
        endcase
    endfunction

    // {V, C, sum}; subtraction goes in as x + ~y + 1
    function automatic logic [33:0] add_with_carry(input word_t x, input word_t y,
                                                   input logic cin);
        logic [32:0] s;
        logic        v;
        s = {1'b0, x} + {1'b0, y} + {32'h0, cin};
        v = (x[31] == y[31]) && (s[31] != x[31]);
        return {v, s};
    endfunction

    task automatic predict(input alu_op_t op, input word_t a, input word_t b,
                           input shift_t sh, input shamt_t amt, input flags_t fl,
                           input logic sf);
        logic [32:0] sh_out;
        logic [33:0] arith;
        logic        is_arith;
        word_t       sb;
        word_t       r;
        logic        c;
        logic        v;
        logic        wr;
        sh_out   = shift_ref(sh, amt, b, fl[FLAG_C]);
        sb       = sh_out[31:0];
        c        = sh_out[32];
        v        = fl[FLAG_V];
        r        = 32'h0;
        arith    = 34'h0;
        is_arith = 1'b1;
        case (op)
            ALU_OP_MOV:                        begin r = sb; is_arith = 1'b0; end
            ALU_OP_NOT:                        begin r = ~sb; is_arith = 1'b0; end
            ALU_OP_AND, ALU_OP_TEST:           begin r = a & sb; is_arith = 1'b0; end
            ALU_OP_XOR, ALU_OP_TEST_EXCLUSIVE: begin r = a ^ sb; is_arith = 1'b0; end
            ALU_OP_OR:                         begin r = a | sb; is_arith = 1'b0; end
            ALU_OP_BIT_CLEAR:                  begin r = a & ~sb; is_arith = 1'b0; end
            ALU_OP_ADD, ALU_OP_CMP_NEG:        arith = add_with_carry(a, sb, 1'b0);
            ALU_OP_ADC:                        arith = add_with_carry(a, sb, fl[FLAG_C]);
            ALU_OP_SUB, ALU_OP_CMP:            arith = add_with_carry(a, ~sb, 1'b1);
            ALU_OP_SBC:                        arith = add_with_carry(a, ~sb, fl[FLAG_C]);
            ALU_OP_SUB_REVERSED:               arith = add_with_carry(sb, ~a, 1'b1);
            default:                           arith = add_with_carry(sb, ~a, fl[FLAG_C]);
        endcase
        if (is_arith) begin
            r = arith[31:0];
            c = arith[32];
            v = arith[33];
        end
        wr = !(op inside {ALU_OP_TEST, ALU_OP_TEST_EXCLUSIVE, ALU_OP_CMP, ALU_OP_CMP_NEG});
        if (sf || !wr) begin
            sticky = {r[31], (r == 32'h0), c, v};
        end
        exp_result.push_back(r);
        exp_write.push_back(wr);
        exp_flags.push_back(sticky);
        exp_tag.push_back(tag_t'(issued_count));
        issued_count++;
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test FAILED");
        $finish;
    endtask

    // strobe held one cycle; busy sampled at the negedge before it
    task automatic issue(input alu_op_t op, input word_t a, input word_t b, input shift_t sh,
                         input shamt_t amt, input flags_t fl, input logic sf);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (busy) begin
            cycles++;
            if (cycles > 200) begin
                abort_run("timeout: busy stayed high, instruction could not be issued");
            end
            @(negedge clk);
        end
        predict(op, a, b, sh, amt, fl, sf);
        @(posedge clk);
        in_valid     <= 1'b1;
        in_op        <= op;
        in_a         <= a;
        in_b         <= b;
        in_shift     <= sh;
        in_shamt     <= amt;
        in_flags     <= fl;
        in_set_flags <= sf;
        @(posedge clk);
        in_valid <= 1'b0;
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while (exp_result.size() != 0) begin
            cycles++;
            if (cycles > 400) begin
                abort_run("timeout: outstanding instructions never retired");
            end
            @(negedge clk);
        end
    endtask

    always @(negedge clk) begin
        if (!reset && out_valid) begin
            if (exp_result.size() == 0) begin
                other_errors++;
                $display("retirement seen with no instruction outstanding");
            end else begin
                e_r = exp_result.pop_front();
                e_w = exp_write.pop_front();
                e_f = exp_flags.pop_front();
                e_t = exp_tag.pop_front();
                retired_count++;
                assert (out_tag === e_t) else begin
                    value_errors++;
                    $display("ERR out_tag expected %h actual %h", e_t, out_tag);
                end
                assert (out_result === e_r) else begin
                    value_errors++;
                    $display("ERR out_result expected %h actual %h tag %h", e_r, out_result,
                             e_t);
                end
                assert (out_write === e_w) else begin
                    value_errors++;
                    $display("ERR out_write expected %h actual %h tag %h", e_w, out_write, e_t);
                end
                assert (out_flags === e_f) else begin
                    value_errors++;
                    $display("ERR out_flags expected %h actual %h tag %h", e_f, out_flags, e_t);
                end
            end
        end
    end

    initial begin
        rng_state     = 32'hd26a5381;
        sticky        = 4'h0;
        issued_count  = 0;
        retired_count = 0;
        value_errors  = 0;
        other_errors  = 0;
        reset         = 1'b1;
        in_valid      = 1'b0;
        in_op         = ALU_OP_MOV;
        in_a          = 32'h0;
        in_b          = 32'h0;
        in_shift      = SHIFT_LSL;
        in_shamt      = 5'd0;
        in_flags      = 4'h0;
        in_set_flags  = 1'b0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        assert (busy === 1'b0) else begin
            value_errors++;
            $display("ERR busy expected %h actual %h", 1'b0, busy);
        end
        assert (out_valid === 1'b0) else begin
            value_errors++;
            $display("ERR out_valid expected %h actual %h", 1'b0, out_valid);
        end

        // every opcode with an unshifted operand
        for (k = 0; k < 16; k++) begin
            for (j = 0; j < 4; j++) begin
                rv = next_random();
                issue(alu_op_t'(k), rv, (j == 0) ? rv : next_random(), shift_t'(rv[1:0]),
                      5'd0, flags_t'(rv[7:4]), rv[8] | j[0]);
            end
        end

        // each shift type through MOV and flag-setting AND
        for (k = 0; k < 4; k++) begin
            for (j = 0; j < 10; j++) begin
                rv = next_random();
                issue(ALU_OP_MOV, next_random(), next_random(), shift_t'(k),
                      (j == 0) ? 5'd0 : (j == 1) ? 5'd31 : shamt_t'(rv[4:0]),
                      flags_t'(rv[11:8]), rv[12]);
                issue(ALU_OP_AND, next_random(), next_random(), shift_t'(k),
                      shamt_t'(rv[20:16]), flags_t'(rv[27:24]), 1'b1);
            end
        end

        // long and short shifts interleaved so retire has to reorder
        for (k = 0; k < 16; k++) begin
            rv = next_random();
            issue(alu_op_t'(rv[3:0]), next_random(), next_random(), shift_t'(rv[5:4]),
                  k[0] ? shamt_t'(rv[6]) : 5'd31, flags_t'(rv[11:8]), rv[12]);
        end

        // flag register only moves on set_flags or compares
        issue(ALU_OP_ADD, 32'hffffffff, 32'h1, SHIFT_LSL, 5'd0, 4'hf, 1'b0);
        issue(ALU_OP_CMP, 32'h5, 32'h5, SHIFT_LSL, 5'd0, 4'h0, 1'b0);
        issue(ALU_OP_MOV, 32'h0, 32'h80000000, SHIFT_LSL, 5'd0, 4'h0, 1'b0);
        issue(ALU_OP_SUB, 32'h0, 32'h1, SHIFT_LSL, 5'd0, 4'h0, 1'b1);
        for (k = 0; k < 12; k++) begin
            rv = next_random();
            issue(alu_op_t'(rv[3:0]), next_random(), next_random(), shift_t'(rv[5:4]),
                  shamt_t'(rv[10:6]), flags_t'(rv[15:12]), rv[16] & rv[17]);
        end

        // fill every lane so busy holds until the first retirement
        wait_drain();
        for (k = 0; k < `NUM_LANES; k++) begin
            issue(ALU_OP_MOV, next_random(), next_random(), SHIFT_ROR, 5'd31, 4'h0, 1'b0);
        end
        @(negedge clk);
        wait_cycles = 0;
        while (!out_valid) begin
            assert (busy === 1'b1) else begin
                value_errors++;
                $display("ERR busy expected %h actual %h", 1'b1, busy);
            end
            wait_cycles++;
            if (wait_cycles > 100) begin
                abort_run("timeout: no retirement with all lanes full");
            end
            @(negedge clk);
        end
        issue(ALU_OP_ADD, next_random(), next_random(), SHIFT_LSL, 5'd3, 4'h2, 1'b1);
        wait_drain();
        repeat (10) @(negedge clk);

        if (retired_count != issued_count) begin
            other_errors++;
            $display("retired count does not match issued count");
        end
        $display("errors: %0d value mismatches, %0d other failures, %0d of %0d retired",
                 value_errors, other_errors, retired_count, issued_count);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== alu_cluster.f ====
+incdir+.
alu_types_pkg.sv
isa_pkg.sv
lane_if.sv
shift_unit.sv
alu.sv
exec_lane.sv
dispatch.sv
retire.sv
alu_cluster.sv
alu_cluster_tb.sv
